//--- common/udp_echo_defines.svh
`ifndef UDP_ECHO_DEFINES_SVH
`define UDP_ECHO_DEFINES_SVH

// Destination port served by the echo application
`define UDP_ECHO_PORT 16'd1234

// Payload FIFO entries, power of two
`define UDP_FIFO_DEPTH 16

// Seven segment digits, one per nibble of an IPv4 address
`define UDP_HEX_DIGITS 8

// Red LED count
`define UDP_LED_WIDTH 18

`endif

//--- common/udp_echo_pkg.sv
`default_nettype none

package udp_echo_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [15:0] port_t;
    typedef logic [31:0] ipv4_t;
    typedef logic [15:0] len_t;

    // One payload byte as it moves through the FIFO
    typedef struct packed {
        byte_t data;
        logic  last;
    } beat_t;

    // Active low, bit 0 is segment a
    typedef logic [6:0] seg_t;

endpackage

`default_nettype wire

//--- design/hex_display.sv
`timescale 1ns/1ns
`default_nettype none

module hex_display import udp_echo_pkg::*; (
    input  logic [3:0] i_nibble,
    output seg_t       o_seg
);

    seg_t pattern;

    // Bit 0 is segment a, lit high
    always_comb begin
        case (i_nibble)
            4'h0:    pattern = 7'h3f;
            4'h1:    pattern = 7'h06;
            4'h2:    pattern = 7'h5b;
            4'h3:    pattern = 7'h4f;
            4'h4:    pattern = 7'h66;
            4'h5:    pattern = 7'h6d;
            4'h6:    pattern = 7'h7d;
            4'h7:    pattern = 7'h07;
            4'h8:    pattern = 7'h7f;
            4'h9:    pattern = 7'h6f;
            4'ha:    pattern = 7'h77;
            4'hb:    pattern = 7'h7c;
            4'hc:    pattern = 7'h39;
            4'hd:    pattern = 7'h5e;
            4'he:    pattern = 7'h79;
            default: pattern = 7'h71;
        endcase
    end

    // Board segments are active low
    assign o_seg = ~pattern;

endmodule

`default_nettype wire

//--- udp_rx/udp_port_filter.sv
`timescale 1ns/1ns
`default_nettype none

`include "udp_echo_defines.svh"

module udp_port_filter import udp_echo_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_hdr_valid,
    output logic  o_hdr_ready,
    input  port_t i_dst_port,
    input  logic  i_pl_valid,
    input  logic  i_pl_last,
    input  byte_t i_pl_data,
    output logic  o_pl_ready,
    output logic  o_beat_valid,
    output beat_t o_beat,
    input  logic  i_beat_ready,
    output logic  o_reply_valid,
    input  logic  i_reply_ready
);

    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_PASS,
        MODE_DROP
    } mode_t;

    mode_t mode;
    logic  match;
    logic  idle;
    logic  hdr_fire;
    logic  pl_fire;

    assign match = (i_dst_port == `UDP_ECHO_PORT);
    assign idle  = (mode == MODE_IDLE);

    // Headers are only taken between frames
    assign o_reply_valid = i_hdr_valid && match && idle;
    assign o_hdr_ready   = i_hdr_valid && idle && (match ? i_reply_ready : 1'b1);
    assign hdr_fire      = i_hdr_valid && o_hdr_ready;

    // Drop mode swallows the payload
    assign o_beat_valid = i_pl_valid && (mode == MODE_PASS);
    assign o_beat       = '{data: i_pl_data, last: i_pl_last};
    assign o_pl_ready   = ((mode == MODE_PASS) && i_beat_ready) || (mode == MODE_DROP);
    assign pl_fire      = i_pl_valid && o_pl_ready;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            mode <= MODE_IDLE;
        end else begin
            case (mode)
                MODE_IDLE: begin
                    if (hdr_fire) begin
                        mode <= match ? MODE_PASS : MODE_DROP;
                    end
                end
                MODE_PASS, MODE_DROP: begin
                    if (pl_fire && i_pl_last) begin
                        mode <= MODE_IDLE;
                    end
                end
                default: mode <= MODE_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- udp_rx/udp_payload_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module udp_payload_fifo import udp_echo_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_wr_valid,
    input  beat_t i_wr_beat,
    output logic  o_wr_ready,
    output logic  o_rd_valid,
    output beat_t o_rd_beat,
    input  logic  i_rd_ready
);

    localparam int AW = $clog2(DEPTH);

    beat_t         mem [DEPTH];
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;
    logic          full;
    logic          empty;
    logic          wr_fire;
    logic          rd_fire;

    // Extra pointer bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign o_wr_ready = !full;
    assign o_rd_valid = !empty;
    assign wr_fire    = i_wr_valid && !full;
    assign rd_fire    = i_rd_ready && !empty;

    // Head entry is presented without a read request
    assign o_rd_beat = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge i_clk) begin
        if (wr_fire) begin
            mem[wr_ptr[AW-1:0]] <= i_wr_beat;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/udp_echo_status.sv
`timescale 1ns/1ns
`default_nettype none

`include "udp_echo_defines.svh"

module udp_echo_status import udp_echo_pkg::*; (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_rx_fire,
    input  byte_t                           i_rx_data,
    input  logic                            i_rx_last,
    input  logic                            i_reply_fire,
    input  ipv4_t                           i_reply_ip,
    output logic [`UDP_LED_WIDTH-1:0]       o_led,
    output seg_t [`UDP_HEX_DIGITS-1:0]      o_hex
);

    logic  in_frame;
    ipv4_t ip_q;

    // Set after the first beat, cleared by the last one
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            in_frame <= 1'b0;
            o_led    <= '0;
        end else if (i_rx_fire) begin
            if (!in_frame) begin
                o_led <= {{(`UDP_LED_WIDTH - $bits(byte_t)){1'b0}}, i_rx_data};
            end
            in_frame <= !i_rx_last;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ip_q <= '0;
        end else if (i_reply_fire) begin
            ip_q <= i_reply_ip;
        end
    end

    // Digit 0 shows the lowest nibble
    for (genvar k = 0; k < `UDP_HEX_DIGITS; k++) begin : g_digit
        hex_display u_hex (
            .i_nibble (ip_q[4*k +: 4]),
            .o_seg    (o_hex[k])
        );
    end

endmodule

`default_nettype wire

//--- design/udp_echo_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "udp_echo_defines.svh"

module udp_echo_top import udp_echo_pkg::*; (
    input  logic                        i_clk,
    input  logic                        i_rst,
    // Header from the stack
    input  logic                        i_hdr_valid,
    output logic                        o_hdr_ready,
    input  ipv4_t                       i_src_ip,
    input  port_t                       i_src_port,
    input  port_t                       i_dst_port,
    input  len_t                        i_length,
    // Payload from the stack
    input  logic                        i_pl_valid,
    output logic                        o_pl_ready,
    input  byte_t                       i_pl_data,
    input  logic                        i_pl_last,
    // Application receive stream
    output logic                        o_rx_valid,
    input  logic                        i_rx_ready,
    output byte_t                       o_rx_data,
    output logic                        o_rx_last,
    // Looped back payload
    output logic                        o_tx_pl_valid,
    output byte_t                       o_tx_pl_data,
    output logic                        o_tx_pl_last,
    // Reply header
    output logic                        o_tx_hdr_valid,
    input  logic                        i_tx_hdr_ready,
    output ipv4_t                       o_tx_dst_ip,
    output port_t                       o_tx_src_port,
    output port_t                       o_tx_dst_port,
    output len_t                        o_tx_length,
    // Status
    output logic [`UDP_LED_WIDTH-1:0]   o_led,
    output seg_t [`UDP_HEX_DIGITS-1:0]  o_hex
);

    logic  beat_valid;
    beat_t beat;
    logic  beat_ready;
    beat_t rd_beat;
    logic  rx_fire;
    logic  reply_fire;

    udp_port_filter u_filter (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_hdr_valid   (i_hdr_valid),
        .o_hdr_ready   (o_hdr_ready),
        .i_dst_port    (i_dst_port),
        .i_pl_valid    (i_pl_valid),
        .i_pl_last     (i_pl_last),
        .i_pl_data     (i_pl_data),
        .o_pl_ready    (o_pl_ready),
        .o_beat_valid  (beat_valid),
        .o_beat        (beat),
        .i_beat_ready  (beat_ready),
        .o_reply_valid (o_tx_hdr_valid),
        .i_reply_ready (i_tx_hdr_ready)
    );

    udp_payload_fifo #(
        .DEPTH (`UDP_FIFO_DEPTH)
    ) u_fifo (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_wr_valid (beat_valid),
        .i_wr_beat  (beat),
        .o_wr_ready (beat_ready),
        .o_rd_valid (o_rx_valid),
        .o_rd_beat  (rd_beat),
        .i_rd_ready (i_rx_ready)
    );

    assign o_rx_data = rd_beat.data;
    assign o_rx_last = rd_beat.last;
    assign rx_fire   = o_rx_valid && i_rx_ready;

    // Echo whatever the application takes
    assign o_tx_pl_valid = rx_fire;
    assign o_tx_pl_data  = o_rx_data;
    assign o_tx_pl_last  = o_rx_last;

    // Reply goes back to the sender
    assign o_tx_dst_ip   = i_src_ip;
    assign o_tx_src_port = i_dst_port;
    assign o_tx_dst_port = i_src_port;
    assign o_tx_length   = i_length;
    assign reply_fire    = o_tx_hdr_valid && i_tx_hdr_ready;

    udp_echo_status u_status (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_rx_fire    (rx_fire),
        .i_rx_data    (o_rx_data),
        .i_rx_last    (o_rx_last),
        .i_reply_fire (reply_fire),
        .i_reply_ip   (o_tx_dst_ip),
        .o_led        (o_led),
        .o_hex        (o_hex)
    );

endmodule

`default_nettype wire

//--- dv/udp_echo_chk.sv
`timescale 1ns/1ns
`default_nettype none

module udp_echo_chk import udp_echo_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_hdr_valid,
    input  logic  i_rx_valid,
    input  logic  i_rx_ready,
    input  byte_t i_rx_data,
    input  logic  i_rx_last,
    input  logic  i_tx_pl_valid,
    input  logic  i_tx_hdr_valid
);

    // Application stream holds until taken
    a_rx_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        i_rx_valid && !i_rx_ready |=> i_rx_valid && $stable({i_rx_last, i_rx_data}))
        else $error("o_rx_valid dropped or its data changed before the transfer");

    a_tx_pl_with_ready: assert property (@(posedge i_clk) disable iff (i_rst)
        i_tx_pl_valid |-> i_rx_ready)
        else $error("o_tx_pl_valid was high while i_rx_ready was low");

    // A reply only exists while a header is offered
    a_reply_needs_hdr: assert property (@(posedge i_clk) disable iff (i_rst)
        i_tx_hdr_valid |-> i_hdr_valid)
        else $error("o_tx_hdr_valid was high without i_hdr_valid");

endmodule

`default_nettype wire

//--- dv/udp_echo_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "udp_echo_defines.svh"

module udp_echo_tb import udp_echo_pkg::*; ();

    localparam int TIMEOUT = 200;

    logic                       i_clk;
    logic                       i_rst;
    logic                       i_hdr_valid;
    logic                       o_hdr_ready;
    ipv4_t                      i_src_ip;
    port_t                      i_src_port;
    port_t                      i_dst_port;
    len_t                       i_length;
    logic                       i_pl_valid;
    logic                       o_pl_ready;
    byte_t                      i_pl_data;
    logic                       i_pl_last;
    logic                       o_rx_valid;
    logic                       i_rx_ready;
    byte_t                      o_rx_data;
    logic                       o_rx_last;
    logic                       o_tx_pl_valid;
    byte_t                      o_tx_pl_data;
    logic                       o_tx_pl_last;
    logic                       o_tx_hdr_valid;
    logic                       i_tx_hdr_ready;
    ipv4_t                      o_tx_dst_ip;
    port_t                      o_tx_src_port;
    port_t                      o_tx_dst_port;
    len_t                       o_tx_length;
    logic [`UDP_LED_WIDTH-1:0]  o_led;
    seg_t [`UDP_HEX_DIGITS-1:0] o_hex;

    logic [31:0] lcg_state;
    logic [31:0] stall_rnd;
    logic        stall_en;
    int          errors;
    int          tests;
    int          failed_tests;
    byte_t       pl_q[$];
    logic [8:0]  rx_q[$];
    logic [8:0]  tx_q[$];
    logic [79:0] reply_q[$];

    udp_echo_top dut (.*);

    bind udp_echo_top udp_echo_chk chk (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_hdr_valid    (i_hdr_valid),
        .i_rx_valid     (o_rx_valid),
        .i_rx_ready     (i_rx_ready),
        .i_rx_data      (o_rx_data),
        .i_rx_last      (o_rx_last),
        .i_tx_pl_valid  (o_tx_pl_valid),
        .i_tx_hdr_valid (o_tx_hdr_valid)
    );

    always #5 i_clk = ~i_clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Standard digit table, lit high, then inverted for the board
    function automatic seg_t seg_ref(input logic [3:0] n);
        logic [6:0] lit;
        case (n)
            4'h0: lit = 7'h3f;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5b;
            4'h3: lit = 7'h4f;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6d;
            4'h6: lit = 7'h7d;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7f;
            4'h9: lit = 7'h6f;
            4'ha: lit = 7'h77;
            4'hb: lit = 7'h7c;
            4'hc: lit = 7'h39;
            4'hd: lit = 7'h5e;
            4'he: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    // Consumer side of the application stream
    always @(posedge i_clk) begin
        #1;
        if (stall_en) begin
            stall_rnd = next_rand();
            i_rx_ready = stall_rnd[30];
        end else begin
            i_rx_ready = 1'b1;
        end
    end

    // Inputs move 1 ns after the rising edge, so the falling edge sees settled values
    always @(negedge i_clk) begin
        if (!i_rst) begin
            if (o_rx_valid && i_rx_ready) begin
                rx_q.push_back({o_rx_last, o_rx_data});
            end
            if (o_tx_pl_valid) begin
                tx_q.push_back({o_tx_pl_last, o_tx_pl_data});
            end
            if (o_tx_hdr_valid && i_tx_hdr_ready) begin
                reply_q.push_back({o_tx_dst_ip, o_tx_src_port, o_tx_dst_port, o_tx_length});
            end
        end
    end

    task automatic check_val(input string name, input logic [79:0] got, input logic [79:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic count_failure(input string msg);
        $display("ERROR %s", msg);
        errors++;
    endtask

    task automatic step_until(input bit on_payload, output bit accepted);
        int cycles;
        accepted = 1'b0;
        for (cycles = 0; cycles < TIMEOUT && !accepted; cycles++) begin
            @(negedge i_clk);
            accepted = on_payload ? o_pl_ready : o_hdr_ready;
            @(posedge i_clk);
            #1;
        end
    endtask

    task automatic new_payload(input int count);
        logic [31:0] r;
        pl_q.delete();
        rx_q.delete();
        tx_q.delete();
        reply_q.delete();
        repeat (count) begin
            r = next_rand();
            pl_q.push_back(r[23:16]);
        end
    endtask

    task automatic send_frame(input ipv4_t ip, input port_t sp, input port_t dp);
        bit accepted;
        int idx;
        i_src_ip    = ip;
        i_src_port  = sp;
        i_dst_port  = dp;
        i_length    = len_t'(pl_q.size() + 8);
        i_hdr_valid = 1'b1;
        step_until(1'b0, accepted);
        i_hdr_valid = 1'b0;
        if (!accepted) begin
            count_failure("header was not accepted before the timeout");
            return;
        end
        for (idx = 0; idx < pl_q.size(); idx++) begin
            i_pl_valid = 1'b1;
            i_pl_data  = pl_q[idx];
            i_pl_last  = (idx == pl_q.size() - 1);
            step_until(1'b1, accepted);
            if (!accepted) begin
                count_failure("payload byte was not accepted before the timeout");
                break;
            end
        end
        i_pl_valid = 1'b0;
        i_pl_last  = 1'b0;
    endtask

    task automatic wait_rx(input int count);
        int cycles;
        for (cycles = 0; cycles < TIMEOUT && rx_q.size() < count; cycles++) begin
            @(posedge i_clk);
            #1;
        end
        if (rx_q.size() < count) begin
            count_failure("application stream stopped before the whole frame arrived");
        end
    endtask

    // Received and echoed bytes against the sent payload
    task automatic check_frame();
        int i;
        check_val("o_rx byte count", 80'(rx_q.size()), 80'(pl_q.size()));
        for (i = 0; i < rx_q.size() && i < pl_q.size(); i++) begin
            check_val("o_rx_data", 80'(rx_q[i][7:0]), 80'(pl_q[i]));
            check_val("o_rx_last", 80'(rx_q[i][8]), 80'(i == pl_q.size() - 1));
        end
        check_val("o_tx_pl byte count", 80'(tx_q.size()), 80'(pl_q.size()));
        for (i = 0; i < tx_q.size() && i < pl_q.size(); i++) begin
            check_val("o_tx_pl_data", 80'(tx_q[i][7:0]), 80'(pl_q[i]));
            check_val("o_tx_pl_last", 80'(tx_q[i][8]), 80'(i == pl_q.size() - 1));
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: FAILED", name);
            failed_tests++;
        end
    endtask

    task automatic test_reset();
        int e0;
        int k;
        e0 = errors;
        check_val("o_rx_valid", 80'(o_rx_valid), 80'(0));
        check_val("o_hdr_ready", 80'(o_hdr_ready), 80'(0));
        check_val("o_pl_ready", 80'(o_pl_ready), 80'(0));
        check_val("o_tx_hdr_valid", 80'(o_tx_hdr_valid), 80'(0));
        check_val("o_led", 80'(o_led), 80'(0));
        for (k = 0; k < `UDP_HEX_DIGITS; k++) begin
            check_val($sformatf("o_hex[%0d]", k), 80'(o_hex[k]), 80'(seg_ref(4'h0)));
        end
        end_test("reset state", e0);
    endtask

    task automatic test_pass_frame();
        int e0;
        e0 = errors;
        new_payload(6);
        send_frame(32'h0a00_0002, 16'd40000, `UDP_ECHO_PORT);
        wait_rx(pl_q.size());
        check_frame();
        check_val("reply count", 80'(reply_q.size()), 80'(1));
        end_test("matching frame in order", e0);
    endtask

    task automatic test_drop_frame();
        int e0;
        e0 = errors;
        new_payload(5);
        send_frame(32'h0a00_0003, 16'd40001, 16'd80);
        check_val("reply count after drop", 80'(reply_q.size()), 80'(0));
        check_val("rx count after drop", 80'(rx_q.size()), 80'(0));
        new_payload(4);
        send_frame(32'h0a00_0003, 16'd40001, `UDP_ECHO_PORT);
        wait_rx(pl_q.size());
        check_frame();
        check_val("reply count", 80'(reply_q.size()), 80'(1));
        end_test("other port dropped", e0);
    endtask

    task automatic test_reply_fields();
        int e0;
        e0 = errors;
        new_payload(3);
        send_frame(32'hc0a8_0107, 16'd5555, `UDP_ECHO_PORT);
        wait_rx(pl_q.size());
        check_val("reply count", 80'(reply_q.size()), 80'(1));
        if (reply_q.size() > 0) begin
            check_val("reply header", reply_q[0],
                {32'hc0a8_0107, `UDP_ECHO_PORT, 16'd5555, 16'd11});
        end
        end_test("reply header fields", e0);
    endtask

    task automatic test_stalled_rx();
        int e0;
        e0 = errors;
        stall_en = 1'b1;
        new_payload(2 * `UDP_FIFO_DEPTH + 7);
        send_frame(32'h0a00_0004, 16'd40002, `UDP_ECHO_PORT);
        wait_rx(pl_q.size());
        stall_en = 1'b0;
        check_frame();
        end_test("stalled application stream", e0);
    endtask

    task automatic test_status();
        int e0;
        int k;
        ipv4_t ip;
        e0 = errors;
        ip = 32'hfedc_ba98;
        new_payload(7);
        send_frame(ip, 16'd40003, `UDP_ECHO_PORT);
        wait_rx(pl_q.size());
        check_val("o_led", 80'(o_led), 80'(pl_q[0]));
        for (k = 0; k < `UDP_HEX_DIGITS; k++) begin
            check_val($sformatf("o_hex[%0d]", k), 80'(o_hex[k]), 80'(seg_ref(ip[4*k +: 4])));
        end
        end_test("status displays", e0);
    endtask

    initial begin
        lcg_state      = 32'h8947_26a0;
        stall_en       = 1'b0;
        errors         = 0;
        tests          = 0;
        failed_tests   = 0;
        i_clk          = 1'b0;
        i_rst          = 1'b1;
        i_hdr_valid    = 1'b0;
        i_src_ip       = '0;
        i_src_port     = '0;
        i_dst_port     = '0;
        i_length       = '0;
        i_pl_valid     = 1'b0;
        i_pl_data      = '0;
        i_pl_last      = 1'b0;
        i_rx_ready     = 1'b1;
        i_tx_hdr_ready = 1'b1;
        repeat (16) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        test_reset();
        test_pass_frame();
        test_drop_frame();
        test_reply_fields();
        test_stalled_rx();
        test_status();
        $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+common
common/udp_echo_pkg.sv
design/hex_display.sv
udp_rx/udp_port_filter.sv
udp_rx/udp_payload_fifo.sv
design/udp_echo_status.sv
design/udp_echo_top.sv
dv/udp_echo_chk.sv
dv/udp_echo_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := udp_echo_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)
